/* remap_pkg.sv */
`default_nettype none

package remap_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    localparam int num_lanes = 8;
    localparam int pixel_w   = 8;
    localparam int resid_w   = 6;
    localparam int win_w     = 7;

    // Largest stride the unit supports
    localparam int stride_max = 3;

    typedef logic [2:0] patch_t;
    typedef logic [2:0] stride_t;

    typedef struct packed {
        patch_t  patch;
        stride_t stride;
    } remap_cfg_t;

    // Residues sit above the pixels, as on the data register
    typedef struct packed {
        logic [resid_w-1:0] residues;
        logic [pixel_w-1:0] pixels;
    } pixel_word_t;

    typedef struct packed {
        logic [num_lanes-1:0][win_w-1:0] lane;
    } lane_windows_t;

    typedef logic [num_lanes-1:0]      lane_mask_t;
    typedef logic [num_lanes-1:0][2:0] lane_offsets_t;

    typedef enum logic [1:0] {
        reg_cfg    = 2'd0,
        reg_data   = 2'd1,
        reg_status = 2'd2
    } remap_reg_e;

    typedef enum logic [1:0] {
        st_idle,
        st_ack,
        st_start
    } ctrl_state_e;

    //////////////////////////////////////////////////
    // Lane offset tables, element 0 is lane 1
    //////////////////////////////////////////////////

    localparam lane_offsets_t offsets_s1 = {3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0};
    // Lanes 1, 2, 7 and 8 idle at stride 2
    localparam lane_offsets_t offsets_s2 = {3'd0, 3'd0, 3'd2, 3'd1, 3'd0, 3'd3, 3'd0, 3'd0};
    localparam lane_offsets_t offsets_s3 = {3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd7, 3'd6};

    localparam lane_mask_t mask_s1 = 8'b1111_1111;
    localparam lane_mask_t mask_s2 = 8'b0011_1100;
    localparam lane_mask_t mask_s3 = 8'b1111_1111;

endpackage

`default_nettype wire

/* remap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module remap_ctrl
    import remap_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [15:0] dat_w,
    output logic [15:0] dat_r,
    output logic        ack,
    output remap_cfg_t  cfg,
    output pixel_word_t word,
    output logic        start
);

    ctrl_state_e state;
    remap_reg_e  reg_sel;
    remap_cfg_t  cfg_req;
    logic        req;
    logic        err;
    logic        data_wr;
    logic [15:0] rd_data;

    assign reg_sel = remap_reg_e'(adr);
    assign cfg_req = remap_cfg_t'(dat_w[5:0]);

    // New request only taken while idle
    assign req = (state == st_idle) && cyc && stb;

    function automatic logic cfg_legal(input remap_cfg_t c);
        logic patch_ok;
        logic stride_ok;
        patch_ok  = (c.patch == 3'd3) || (c.patch == 3'd5) || (c.patch == 3'd7);
        stride_ok = (c.stride != 3'd0) && (int'(c.stride) <= stride_max)
                    && (c.stride <= c.patch);
        return patch_ok && stride_ok;
    endfunction

    // Read mux, status carries error above the configuration
    always_comb
    begin
        case (reg_sel)
            reg_cfg:    rd_data = {10'b0, cfg};
            reg_data:   rd_data = {2'b0, word};
            reg_status: rd_data = {9'b0, err, cfg};
            default:    rd_data = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Bus FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= st_idle;
            ack     <= 1'b0;
            start   <= 1'b0;
            data_wr <= 1'b0;
            err     <= 1'b0;
            cfg     <= '0;
            dat_r   <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    start <= 1'b0;
                    if (req)
                    begin
                        ack     <= 1'b1;
                        state   <= st_ack;
                        data_wr <= we && (reg_sel == reg_data);
                        if (!we)
                            dat_r <= rd_data;
                        if (we && (reg_sel == reg_cfg))
                        begin
                            // Bad configuration keeps the old one
                            if (cfg_legal(cfg_req))
                            begin
                                cfg <= cfg_req;
                                err <= 1'b0;
                            end
                            else
                                err <= 1'b1;
                        end
                    end
                end
                st_ack:
                begin
                    ack <= 1'b0;
                    if (data_wr)
                    begin
                        start <= 1'b1;
                        state <= st_start;
                    end
                    else
                        state <= st_idle;
                end
                st_start:
                begin
                    start <= 1'b0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Pixel word register
    always_ff @(posedge clk)
    begin
        if (req && we && (reg_sel == reg_data))
            word <= pixel_word_t'(dat_w[13:0]);
    end

endmodule

`default_nettype wire

/* lane_map.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_map
    import remap_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  stride_t       stride,
    output lane_offsets_t offsets,
    output lane_mask_t    lane_en
);

    lane_offsets_t offsets_sel;
    lane_mask_t    mask_sel;

    // Table row for the current stride, unsupported strides disable every lane
    always_comb
    begin
        case (stride)
            3'd1:
            begin
                offsets_sel = offsets_s1;
                mask_sel    = mask_s1;
            end
            3'd2:
            begin
                offsets_sel = offsets_s2;
                mask_sel    = mask_s2;
            end
            3'd3:
            begin
                offsets_sel = offsets_s3;
                mask_sel    = mask_s3;
            end
            default:
            begin
                offsets_sel = '0;
                mask_sel    = '0;
            end
        endcase
    end

    // Follows a configuration change within one cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            offsets <= '0;
            lane_en <= '0;
        end
        else
        begin
            offsets <= offsets_sel;
            lane_en <= mask_sel;
        end
    end

endmodule

`default_nettype wire

/* window_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module window_extract
    import remap_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  pixel_word_t      word,
    input  patch_t           patch,
    input  stride_t          stride,
    input  logic [2:0]       offset,
    input  logic             en,
    output logic [win_w-1:0] window,
    output logic             valid
);

    logic [win_w-1:0] window_next;

    //////////////////////////////////////////////////
    // Window cut
    //////////////////////////////////////////////////

    // Start position runs 1..8, a window crossing position 8 takes
    // its leading bits from the residues of the previous segment
    function automatic logic [win_w-1:0] cut_window(
        input pixel_word_t w,
        input patch_t      p,
        input stride_t     s,
        input logic [2:0]  k
    );
        int               t;
        int               pos;
        logic             wrap;
        logic [win_w-1:0] win;
        t    = ((int'(k) * int'(s)) % pixel_w) + 1;
        wrap = (t + int'(p) - 1) > pixel_w;
        win  = '0;
        for (int i = 0; i < win_w; i++)
        begin
            pos = t + i;
            if (i < int'(p))
            begin
                if (wrap && (pos <= pixel_w))
                    win[i] = w.residues[pixel_w - pos];
                else
                    win[i] = w.pixels[(pos - 1) % pixel_w];
            end
        end
        return win;
    endfunction

    assign window_next = en ? cut_window(word, patch, stride, offset) : '0;

    // Window held until the next start
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            window <= '0;
            valid  <= 1'b0;
        end
        else
        begin
            valid <= start;
            if (start)
                window <= window_next;
        end
    end

endmodule

`default_nettype wire

/* remap_top.sv */
`timescale 1ns/1ps
`default_nettype none

module remap_top
    import remap_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          cyc,
    input  logic          stb,
    input  logic          we,
    input  logic [1:0]    adr,
    input  logic [15:0]   dat_w,
    output logic [15:0]   dat_r,
    output logic          ack,
    output lane_windows_t windows,
    output lane_mask_t    lane_en,
    output logic          windows_valid
);

    remap_cfg_t           cfg;
    pixel_word_t          word;
    logic                 start;
    lane_offsets_t        offsets;
    logic [num_lanes-1:0] valid_lane;

    remap_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .cfg   (cfg),
        .word  (word),
        .start (start)
    );

    lane_map u_lane_map (
        .clk     (clk),
        .rst     (rst),
        .stride  (cfg.stride),
        .offsets (offsets),
        .lane_en (lane_en)
    );

    // One extractor per clause processor
    for (genvar i = 0; i < num_lanes; i++)
    begin : g_lane
        window_extract u_win (
            .clk    (clk),
            .rst    (rst),
            .start  (start),
            .word   (word),
            .patch  (cfg.patch),
            .stride (cfg.stride),
            .offset (offsets[i]),
            .en     (lane_en[i]),
            .window (windows.lane[i]),
            .valid  (valid_lane[i])
        );
    end

    // All lanes share timing, lane 0 stands for the set
    assign windows_valid = valid_lane[0];

endmodule

`default_nettype wire

/* remap_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module remap_properties
    import remap_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       cyc,
    input logic       stb,
    input logic       we,
    input logic [1:0] adr,
    input logic       ack,
    input logic       windows_valid
);

    logic data_req;

    assign data_req = cyc && stb && we && (adr == reg_data);

    ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held for more than one cycle");

    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(cyc && stb))
        else $error("ack rose without cyc and stb");

    // Accepted data write gives windows_valid two cycles after ack
    valid_after_data: assert property (@(posedge clk) disable iff (rst)
        ($past(ack, 2) && $past(data_req, 3)) |-> windows_valid)
        else $error("windows_valid missing two cycles after a data ack");

    valid_only_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(windows_valid) |-> $past(ack, 2))
        else $error("windows_valid rose without a data ack");

endmodule

bind remap_top remap_properties u_props (
    .clk           (clk),
    .rst           (rst),
    .cyc           (cyc),
    .stb           (stb),
    .we            (we),
    .adr           (adr),
    .ack           (ack),
    .windows_valid (windows_valid)
);

`default_nettype wire

/* remap_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module remap_checker
    import remap_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          cyc,
    input  logic          stb,
    input  logic          we,
    input  logic [1:0]    adr,
    input  logic [15:0]   dat_r,
    input  logic          ack,
    input  lane_windows_t windows,
    input  lane_mask_t    lane_en,
    input  logic          windows_valid,
    input  remap_cfg_t    exp_cfg,
    input  pixel_word_t   exp_word,
    input  logic [15:0]   exp_status,
    input  lane_windows_t gold_win,
    input  lane_mask_t    gold_mask,
    input  logic          gold_en,
    output int            errors,
    output int            checks
);

    logic       req_we;
    logic [1:0] req_adr;
    logic [1:0] data_ack_hist;

    initial
    begin
        errors        = 0;
        checks        = 0;
        data_ack_hist = 2'b00;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Start position 1..8 of a lane's window, 0 when the lane is idle
    function automatic int lane_start(input int s, input int lane);
        int k;
        int t;
        case (s)
            1:       k = lane - 1;
            2:       k = (lane >= 3 && lane <= 6) ? lane % 4 : -1;
            3:       k = (lane + 5) % 8;
            default: k = -1;
        endcase
        if (k < 0)
            return 0;
        t = 1 + k * s;
        while (t > pixel_w)
            t = t - pixel_w;
        return t;
    endfunction

    function automatic logic [win_w-1:0] expected_window(input pixel_word_t w, input int p,
                                                         input int t);
        logic [win_w-1:0] win;
        logic             wrap;
        int               pos;
        win  = '0;
        wrap = (t + p - 1) > pixel_w;
        if (t != 0)
        begin
            for (int i = 0; i < p; i++)
            begin
                pos = t + i;
                if (wrap && pos <= pixel_w)
                    win[i] = w.residues[pixel_w - pos];
                else
                    win[i] = w.pixels[(pos - 1) % pixel_w];
            end
        end
        return win;
    endfunction

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] want);
        checks++;
        if (got !== want)
        begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_windows();
        int               t;
        logic [win_w-1:0] want;
        lane_mask_t       mask;
        mask = '0;
        for (int l = 0; l < num_lanes; l++)
        begin
            t       = lane_start(int'(exp_cfg.stride), l + 1);
            mask[l] = (t != 0);
            want    = expected_window(exp_word, int'(exp_cfg.patch), t);
            compare_value($sformatf("windows.lane[%0d]", l), 16'(windows.lane[l]), 16'(want));
            if (gold_en)
                compare_value($sformatf("windows.lane[%0d] (golden)", l),
                              16'(windows.lane[l]), 16'(gold_win.lane[l]));
        end
        compare_value("lane_en", 16'(lane_en), 16'(mask));
        if (gold_en)
            compare_value("lane_en (golden)", 16'(lane_en), 16'(gold_mask));
    endtask

    //////////////////////////////////////////////////
    // Monitor
    //////////////////////////////////////////////////

    // Request as the slave accepted it
    always @(posedge clk)
    begin
        if (cyc && stb && !ack)
        begin
            req_we  <= we;
            req_adr <= adr;
        end
    end

    always @(negedge clk)
    begin
        if (rst)
        begin
            data_ack_hist = 2'b00;
            if (ack !== 1'b0 || windows_valid !== 1'b0 || lane_en !== '0 || windows !== '0)
            begin
                $display("Outputs were not cleared during reset");
                errors++;
            end
        end
        else
        begin
            checks++;
            if (windows_valid !== data_ack_hist[1])
            begin
                $display("windows_valid came out of step with the data write ack");
                errors++;
            end
            if (ack && !req_we && req_adr == reg_status)
                compare_value("dat_r", dat_r, exp_status);
            if (windows_valid)
                check_windows();
            data_ack_hist = {data_ack_hist[0], ack && req_we && (req_adr == reg_data)};
        end
    end

endmodule

`default_nettype wire

/* tb_remap.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_remap
    import remap_pkg::*;
();

    localparam int period_ns  = 20;
    localparam int golden_max = 32;
    localparam int fields     = 12;
    localparam int num_random = 24;
    // About 8 cycles per vector, 10 allowed, plus reset and margin
    localparam int watchdog_ns = (golden_max + num_random) * 10 * period_ns
                                 + 100 * period_ns;

    logic          clk;
    logic          rst;
    logic          cyc;
    logic          stb;
    logic          we;
    logic [1:0]    adr;
    logic [15:0]   dat_w;
    logic [15:0]   dat_r;
    logic          ack;
    lane_windows_t windows;
    lane_mask_t    lane_en;
    logic          windows_valid;

    remap_cfg_t    exp_cfg;
    pixel_word_t   exp_word;
    logic [15:0]   exp_status;
    lane_windows_t gold_win;
    lane_mask_t    gold_mask;
    logic          gold_en;

    logic [15:0]   golden [0:golden_max*fields-1];
    logic [31:0]   rng;
    int            tb_errors;
    int            chk_errors;
    int            chk_checks;
    int            num_golden;

    remap_top dut (
        .clk           (clk),
        .rst           (rst),
        .cyc           (cyc),
        .stb           (stb),
        .we            (we),
        .adr           (adr),
        .dat_w         (dat_w),
        .dat_r         (dat_r),
        .ack           (ack),
        .windows       (windows),
        .lane_en       (lane_en),
        .windows_valid (windows_valid)
    );

    remap_checker chk (
        .clk           (clk),
        .rst           (rst),
        .cyc           (cyc),
        .stb           (stb),
        .we            (we),
        .adr           (adr),
        .dat_r         (dat_r),
        .ack           (ack),
        .windows       (windows),
        .lane_en       (lane_en),
        .windows_valid (windows_valid),
        .exp_cfg       (exp_cfg),
        .exp_word      (exp_word),
        .exp_status    (exp_status),
        .gold_win      (gold_win),
        .gold_mask     (gold_mask),
        .gold_en       (gold_en),
        .errors        (chk_errors),
        .checks        (chk_checks)
    );

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout, the run did not reach its end in time");
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////////////////////////
    // Wishbone master
    //////////////////////////////////////////////////

    task automatic bus_cycle(input logic write, input remap_reg_e addr, input logic [15:0] data);
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = data;
        do
            @(negedge clk);
        while (!ack);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wait_windows();
        int n;
        n = 0;
        while (!windows_valid && n < 6)
        begin
            @(negedge clk);
            n++;
        end
        if (!windows_valid)
        begin
            $display("windows_valid never came after a data write");
            tb_errors++;
        end
        // Step past the valid cycle before the expectations change
        @(negedge clk);
    endtask

    // Status read back carries the configuration in force
    task automatic apply_vector(input logic [5:0] cfg, input pixel_word_t word,
                                input logic [15:0] status);
        exp_cfg    = remap_cfg_t'(status[5:0]);
        exp_word   = word;
        exp_status = status;
        bus_cycle(1'b1, reg_cfg, {10'b0, cfg});
        bus_cycle(1'b0, reg_status, 16'h0000);
        bus_cycle(1'b1, reg_data, {2'b0, word});
        wait_windows();
    endtask

    //////////////////////////////////////////////////
    // Directed and random phases
    //////////////////////////////////////////////////

    task automatic run_golden();
        int b;
        gold_en = 1'b1;
        for (int v = 0; v < golden_max; v++)
        begin
            b = v * fields;
            if (golden[b] === 16'hffff)
                break;
            for (int l = 0; l < num_lanes; l++)
                gold_win.lane[l] = golden[b + 3 + l][win_w-1:0];
            gold_mask = golden[b + 11][num_lanes-1:0];
            apply_vector(golden[b][5:0], pixel_word_t'(golden[b + 1][13:0]), golden[b + 2]);
            num_golden++;
        end
        gold_en = 1'b0;
    endtask

    task automatic run_random();
        remap_cfg_t  cfg;
        pixel_word_t word;
        for (int v = 0; v < num_random; v++)
        begin
            rng        = xorshift(rng);
            cfg.patch  = 3'(3 + 2 * (rng % 3));
            cfg.stride = 3'(1 + ((rng >> 8) % 3));
            word       = pixel_word_t'(rng[29:16]);
            apply_vector(cfg, word, {10'b0, cfg});
        end
    endtask

    initial
    begin
        rst        = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = 2'd0;
        dat_w      = 16'h0000;
        exp_cfg    = '0;
        exp_word   = '0;
        exp_status = 16'h0000;
        gold_win   = '0;
        gold_mask  = '0;
        gold_en    = 1'b0;
        rng        = 32'd37;
        tb_errors  = 0;
        num_golden = 0;
        // Unread entries keep the end marker
        foreach (golden[i])
            golden[i] = 16'hffff;
        $readmemh("remap_golden.txt", golden);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_golden();
        if (num_golden == 0)
        begin
            $display("No vectors were read from remap_golden.txt");
            tb_errors++;
        end
        run_random();

        $display("Vectors %0d golden, %0d random; %0d checks; errors %0d checker, %0d testbench",
                 num_golden, num_random, chk_checks, chk_errors, tb_errors);
        if (tb_errors + chk_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* remap_golden.txt */
// cfg word status win1 win2 win3 win4 win5 win6 win7 win8 mask
// cfg = {patch, stride}, status = {err, cfg in force}, win1 is lane 1
0019 2dca 0019 0002 0005 0002 0001 0004 0006 0002 0005 00ff
0029 2dca 0029 000a 0005 0012 0019 000b 0015 000a 0015 00ff
0039 2dca 0039 004a 0065 002d 0056 002b 0055 002a 0015 00ff
001a 1674 001a 0000 0000 0001 0004 0005 0007 0000 0000 003c
002a 1674 002a 0000 0000 0011 0014 001d 0006 0000 0000 003c
// stride 0 rejected, patch 5 stride 2 stays
0018 2dca 006a 0000 0000 000a 000a 0012 000b 0000 0000 003c
001b 2dca 001b 0002 0006 0002 0001 0002 0005 0004 0005 00ff
002b 2dca 002b 0012 0015 000a 0019 000a 0005 000b 0015 00ff
003b 2dca 003b 002d 0055 004a 0056 002a 0065 002b 0015 00ff
// patch 4, then stride 4, both rejected
0022 1674 007b 001a 0023 0074 000d 0051 003a 0046 0068 00ff
002c 2dca 007b 002d 0055 004a 0056 002a 0065 002b 0015 00ff
0019 1674 0019 0004 0002 0005 0006 0007 0003 0001 0000 00ff

/* files.f */
remap_pkg.sv
remap_ctrl.sv
lane_map.sv
window_extract.sv
remap_top.sv
remap_properties.sv
remap_checker.sv
tb_remap.sv

/* Makefile */
SRCS = $(shell cat files.f)

all: run

obj_dir/Vtb_remap: files.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_remap -f files.f

run: obj_dir/Vtb_remap remap_golden.txt
	./obj_dir/Vtb_remap | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
